/* cam_capture_top.f */
design/cam_pkg.sv
design/luma_capture.sv
design/capture_ctrl.sv
design/pixel_stacker.sv
design/chunk_fifo.sv
design/cam_capture_top.sv
tests/cam_capture_chk.sv
tests/cam_capture_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := cam_capture_tb
FILELIST  := cam_capture_top.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Testbench failed
PASS_MSG  := Testbench passed

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/cam_capture_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cam_capture_tb import cam_pkg::*; ();

  // small frame of 90 pixels in five full chunks and one of ten
  localparam int H_RES      = 30;
  localparam int V_RES      = 3;
  localparam int FIFO_DEPTH = 4;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  // one pixel clock period spans four clk_camera cycles
  localparam int SLOT_CYCLES  = 4;
  localparam int VSYNC_SLOTS  = 2;
  localparam int VBACK_SLOTS  = 2;
  localparam int HGAP_SLOTS   = 2;
  localparam int FRAME_SLOTS  = VSYNC_SLOTS + VBACK_SLOTS + V_RES * (H_RES + HGAP_SLOTS);
  localparam int FRAME_CYCLES = FRAME_SLOTS * SLOT_CYCLES;
  localparam int CHUNKS_PER_FRAME = (H_RES * V_RES + PIX_PER_CHUNK - 1) / PIX_PER_CHUNK;
  // longest quiet stretch allowed between two chunks
  localparam int CHUNK_WAIT   = FRAME_CYCLES;
  localparam int WATCHDOG_NS  = (10 * FRAME_CYCLES + RESET_CYCLES + 1000) * CLK_PERIOD;

  logic         clk_camera;
  logic         recent_reset;
  pixel_t       cam_d;
  logic         cam_pclk;
  logic         cam_hsync;
  logic         cam_vsync;
  logic         m_tvalid;
  chunk_t       m_tdata;
  logic         m_tlast;
  logic         m_tready;
  logic         capturing;
  logic         overflow;
  frame_count_t frame_count;

  // separate streams so driver and receiver never race on one seed
  int pix_seed   = 32'h76eabdcf;
  int stall_seed = 32'h76eabdcf;

  // reference model of the chunks expected on the output in order
  chunk_t       exp_data[$];
  logic         exp_last[$];
  frame_count_t exp_frames;

  int checks;
  int mismatches;
  int failures;

  cam_capture_top #(
    .H_RES      (H_RES),
    .V_RES      (V_RES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_dut (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .cam_d_i       (cam_d),
    .cam_pclk_i    (cam_pclk),
    .cam_hsync_i   (cam_hsync),
    .cam_vsync_i   (cam_vsync),
    .m_tvalid_o    (m_tvalid),
    .m_tdata_o     (m_tdata),
    .m_tlast_o     (m_tlast),
    .m_tready_i    (m_tready),
    .capturing_o   (capturing),
    .overflow_o    (overflow),
    .frame_count_o (frame_count)
  );

  initial begin
    clk_camera = 1'b0;
    forever #(CLK_PERIOD / 2) clk_camera = ~clk_camera;
  end

  // hard stop well past the expected run length
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t ns, the tests did not finish", $time);
    $display("Testbench failed");
    $finish;
  end

  task automatic compare_chunk(input string name, input chunk_t expected, input chunk_t actual);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_count(input string name, input frame_count_t expected,
                               input frame_count_t actual);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("mismatch at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("mismatch at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  // one pixel clock period with data set up while pclk is low
  task automatic pixel_slot(input pixel_t value);
    cam_pclk = 1'b0;
    cam_d    = value;
    repeat (2) @(negedge clk_camera);
    cam_pclk = 1'b1;
    repeat (2) @(negedge clk_camera);
  endtask

  // row with no vsync ahead of it
  task automatic send_stray_row();
    int word;
    cam_hsync = 1'b1;
    repeat (H_RES) begin
      word = $random(pix_seed);
      pixel_slot(word[7:0]);
    end
    cam_hsync = 1'b0;
    repeat (HGAP_SLOTS) pixel_slot(8'h00);
  endtask

  // vsync pulse then V_RES rows optionally logged into the model
  task automatic send_frame(input bit record);
    chunk_t build;
    int     fill;
    int     word;
    pixel_t pix;
    bit     is_last;
    build = '0;
    fill  = 0;
    cam_vsync = 1'b1;
    repeat (VSYNC_SLOTS) pixel_slot(8'h00);
    cam_vsync = 1'b0;
    repeat (VBACK_SLOTS) pixel_slot(8'h00);
    for (int r = 0; r < V_RES; r++) begin
      cam_hsync = 1'b1;
      for (int c = 0; c < H_RES; c++) begin
        word = $random(pix_seed);
        pix  = word[7:0];
        // first pixel of a chunk in the lowest byte
        build[8*fill +: 8] = pix;
        fill++;
        is_last = (r == V_RES - 1) && (c == H_RES - 1);
        if (fill == PIX_PER_CHUNK || is_last) begin
          // short last chunk keeps zeros above its pixels
          if (record) begin
            exp_data.push_back(build);
            exp_last.push_back(is_last);
          end
          build = '0;
          fill  = 0;
        end
        pixel_slot(pix);
      end
      cam_hsync = 1'b0;
      repeat (HGAP_SLOTS) pixel_slot(8'h00);
    end
  endtask

  // take chunks off the stream and hold them against the model
  task automatic receive_chunks(input int count, input bit stalls);
    int got;
    int stall;
    int waited;
    int word;
    bit may_stall;
    got       = 0;
    stall     = 0;
    waited    = 0;
    may_stall = 1'b1;
    while (got < count && waited < CHUNK_WAIT) begin
      @(negedge clk_camera);
      if (stalls && may_stall && stall == 0) begin
        word = $random(stall_seed);
        if (word[0]) begin
          // one to three cycles low and then at least one ready cycle
          stall     = 1 + int'(word[2:1]) % 3;
          may_stall = 1'b0;
        end
      end
      if (stall > 0) begin
        m_tready = 1'b0;
        stall--;
        waited++;
      end else begin
        m_tready  = 1'b1;
        may_stall = 1'b1;
        // valid with ready here means a transfer on the next rising edge
        if (m_tvalid) begin
          if (exp_data.size() == 0) begin
            report_failure("a chunk arrived that no captured frame accounts for");
          end else begin
            compare_chunk("m_tdata_o", exp_data.pop_front(), m_tdata);
            compare_flag("m_tlast_o", exp_last.pop_front(), m_tlast);
          end
          got++;
          waited = 0;
        end else begin
          waited++;
        end
      end
    end
    if (got < count) begin
      report_failure($sformatf("only %0d of %0d chunks arrived", got, count));
    end
  endtask

  task automatic expect_no_chunk(input int cycles, input string when);
    bit seen;
    seen = 1'b0;
    repeat (cycles) begin
      @(negedge clk_camera);
      if (m_tvalid) begin
        seen = 1'b1;
      end
    end
    if (seen) begin
      report_failure({"a chunk appeared ", when});
    end
  endtask

  task automatic wait_for_overflow(input int cycles);
    int waited;
    waited = 0;
    while (!overflow && waited < cycles) begin
      @(negedge clk_camera);
      waited++;
    end
    if (!overflow) begin
      report_failure("overflow_o never rose while the output was stalled");
    end
  endtask

  task automatic confirm_all_delivered();
    if (exp_data.size() != 0) begin
      report_failure($sformatf("%0d expected chunks never arrived", exp_data.size()));
      exp_data.delete();
      exp_last.delete();
    end
  endtask

  task automatic verify_reset_values();
    compare_flag("m_tvalid_o", 1'b0, m_tvalid);
    compare_flag("overflow_o", 1'b0, overflow);
    compare_flag("capturing_o", 1'b0, capturing);
    compare_count("frame_count_o", '0, frame_count);
  endtask

  // stray row must be ignored before one clean frame
  task automatic capture_first_frame();
    fork
      send_stray_row();
      expect_no_chunk((H_RES + HGAP_SLOTS + 16) * SLOT_CYCLES,
                      "before the first frame boundary");
    join
    fork
      send_frame(1'b1);
      receive_chunks(CHUNKS_PER_FRAME, 1'b0);
    join
    confirm_all_delivered();
    exp_frames = exp_frames + 1'b1;
    compare_count("frame_count_o", exp_frames, frame_count);
    compare_flag("capturing_o", 1'b1, capturing);
  endtask

  task automatic ride_short_stalls();
    fork
      send_frame(1'b1);
      receive_chunks(CHUNKS_PER_FRAME, 1'b1);
    join
    confirm_all_delivered();
    exp_frames = exp_frames + 1'b1;
    compare_count("frame_count_o", exp_frames, frame_count);
    compare_flag("overflow_o", 1'b0, overflow);
  endtask

  // queue, output register and stacker together hold one frame
  task automatic recover_from_overflow();
    m_tready = 1'b0;
    send_frame(1'b1);
    exp_frames = exp_frames + 1'b1;
    fork
      // queue already full so this frame is lost from its first pixel
      send_frame(1'b0);
      begin
        // drain while the rest of the dropped frame still arrives
        wait_for_overflow(FRAME_CYCLES);
        receive_chunks(CHUNKS_PER_FRAME, 1'b0);
        expect_no_chunk(FRAME_CYCLES, "from the dropped frame");
      end
    join
    compare_flag("overflow_o", 1'b1, overflow);
    compare_flag("capturing_o", 1'b0, capturing);
    compare_count("frame_count_o", exp_frames, frame_count);
    confirm_all_delivered();
    fork
      send_frame(1'b1);
      receive_chunks(CHUNKS_PER_FRAME, 1'b0);
    join
    confirm_all_delivered();
    exp_frames = exp_frames + 1'b1;
    compare_count("frame_count_o", exp_frames, frame_count);
    compare_flag("overflow_o", 1'b1, overflow);
  endtask

  task automatic stream_two_frames();
    fork
      begin
        send_frame(1'b1);
        send_frame(1'b1);
      end
      receive_chunks(2 * CHUNKS_PER_FRAME, 1'b0);
    join
    confirm_all_delivered();
    exp_frames = exp_frames + 2'd2;
    compare_count("frame_count_o", exp_frames, frame_count);
  endtask

  initial begin
    recent_reset = 1'b1;
    cam_d        = '0;
    cam_pclk     = 1'b0;
    cam_hsync    = 1'b0;
    cam_vsync    = 1'b0;
    m_tready     = 1'b1;
    exp_frames   = '0;
    checks       = 0;
    mismatches   = 0;
    failures     = 0;
    repeat (RESET_CYCLES) @(negedge clk_camera);
    recent_reset = 1'b0;
    @(negedge clk_camera);
    verify_reset_values();
    capture_first_frame();
    ride_short_stalls();
    recover_from_overflow();
    stream_two_frames();
    $display("%0d checks, %0d mismatches, %0d other errors", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/cam_capture_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module cam_capture_chk import cam_pkg::*; (
  input wire          clk_camera,
  input wire          recent_reset,
  input wire          tvalid_i,
  input chunk_t       tdata_i,
  input wire          tlast_i,
  input wire          tready_i,
  input wire          capturing_i,
  input wire          overflow_i,
  input frame_count_t frame_count_i
);

  // offered chunk stays put until the receiver takes it
  a_hold_chunk: assert property (@(posedge clk_camera) disable iff (recent_reset)
    tvalid_i && !tready_i |=> tvalid_i && $stable(tdata_i) && $stable(tlast_i))
    else $error("output chunk dropped or changed while tready was low");

  // overflow is sticky
  a_overflow_sticky: assert property (@(posedge clk_camera) disable iff (recent_reset)
    overflow_i |=> overflow_i)
    else $error("overflow flag fell without a reset");

  // reset clears every output on the next edge
  a_reset_quiet: assert property (@(posedge clk_camera)
    recent_reset |=> !tvalid_i && !overflow_i && !capturing_i && frame_count_i == '0)
    else $error("outputs active during reset");

endmodule

bind cam_capture_top cam_capture_chk i_chk (
  .clk_camera    (clk_camera),
  .recent_reset  (recent_reset),
  .tvalid_i      (m_tvalid_o),
  .tdata_i       (m_tdata_o),
  .tlast_i       (m_tlast_o),
  .tready_i      (m_tready_i),
  .capturing_i   (capturing_o),
  .overflow_i    (overflow_o),
  .frame_count_i (frame_count_o)
);

`default_nettype wire

/* design/cam_capture_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cam_capture_top import cam_pkg::*; #(
  parameter int H_RES      = DEF_H_RES,
  parameter int V_RES      = DEF_V_RES,
  parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  wire          clk_camera,
  input  wire          recent_reset,
  input  pixel_t       cam_d_i,
  input  wire          cam_pclk_i,
  input  wire          cam_hsync_i,
  input  wire          cam_vsync_i,
  output logic         m_tvalid_o,
  output chunk_t       m_tdata_o,
  output logic         m_tlast_o,
  input  wire          m_tready_i,
  output logic         capturing_o,
  output logic         overflow_o,
  output frame_count_t frame_count_o
);

  // camera pixels with position
  logic    pix_valid;
  pixel_t  pix_data;
  hcount_t pix_hcount;
  vcount_t pix_vcount;
  logic    frame_start;

  // gated pixels into the stacker
  logic   stk_valid;
  pixel_t stk_data;
  logic   stk_last;
  logic   stk_abort;
  logic   stk_ready;

  // packed chunks into the queue
  logic   chunk_valid;
  chunk_t chunk_data;
  logic   chunk_last;
  logic   chunk_ready;

  luma_capture #(
    .H_RES(H_RES)
  ) i_luma (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .cam_d_i       (cam_d_i),
    .cam_pclk_i    (cam_pclk_i),
    .cam_hsync_i   (cam_hsync_i),
    .cam_vsync_i   (cam_vsync_i),
    .pix_valid_o   (pix_valid),
    .pix_data_o    (pix_data),
    .pix_hcount_o  (pix_hcount),
    .pix_vcount_o  (pix_vcount),
    .frame_start_o (frame_start)
  );

  capture_ctrl #(
    .H_RES(H_RES),
    .V_RES(V_RES)
  ) i_ctrl (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pix_valid_i   (pix_valid),
    .pix_data_i    (pix_data),
    .pix_hcount_i  (pix_hcount),
    .pix_vcount_i  (pix_vcount),
    .frame_start_i (frame_start),
    .stk_ready_i   (stk_ready),
    .stk_valid_o   (stk_valid),
    .stk_data_o    (stk_data),
    .stk_last_o    (stk_last),
    .stk_abort_o   (stk_abort),
    .capturing_o   (capturing_o),
    .overflow_o    (overflow_o),
    .frame_count_o (frame_count_o)
  );

  pixel_stacker i_stacker (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pix_valid_i   (stk_valid),
    .pix_data_i    (stk_data),
    .pix_last_i    (stk_last),
    .abort_i       (stk_abort),
    .pix_ready_o   (stk_ready),
    .chunk_valid_o (chunk_valid),
    .chunk_data_o  (chunk_data),
    .chunk_last_o  (chunk_last),
    .chunk_ready_i (chunk_ready)
  );

  chunk_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_fifo (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .wr_valid_i   (chunk_valid),
    .wr_data_i    (chunk_data),
    .wr_last_i    (chunk_last),
    .wr_ready_o   (chunk_ready),
    .rd_valid_o   (m_tvalid_o),
    .rd_data_o    (m_tdata_o),
    .rd_last_o    (m_tlast_o),
    .rd_ready_i   (m_tready_i)
  );

endmodule

`default_nettype wire

/* design/chunk_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module chunk_fifo import cam_pkg::*; #(
  parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  wire    clk_camera,
  input  wire    recent_reset,
  input  wire    wr_valid_i,
  input  chunk_t wr_data_i,
  input  wire    wr_last_i,
  output logic   wr_ready_o,
  output logic   rd_valid_o,
  output chunk_t rd_data_o,
  output logic   rd_last_o,
  input  wire    rd_ready_i
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // ring storage, chunk and tlast side by side
  chunk_t mem_data [FIFO_DEPTH];
  logic   mem_last [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // entries in the ring, output register excluded
  logic [CNT_W-1:0] count;

  logic wr_fire;
  logic out_load;
  logic pop;
  logic bypass;
  logic push;

  assign wr_ready_o = (count != CNT_W'(FIFO_DEPTH));
  assign wr_fire    = wr_valid_i & wr_ready_o;
  // output register empty or being taken this cycle
  assign out_load   = ~rd_valid_o | rd_ready_i;
  assign pop        = out_load & (count != '0);
  // empty ring, write goes straight to the output
  assign bypass     = out_load & (count == '0) & wr_fire;
  assign push       = wr_fire & ~bypass;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leave the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
      if (out_load) begin
        rd_valid_o <= pop | bypass;
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (push) begin
      mem_data[wr_ptr] <= wr_data_i;
      mem_last[wr_ptr] <= wr_last_i;
    end
    if (pop) begin
      rd_data_o <= mem_data[rd_ptr];
      rd_last_o <= mem_last[rd_ptr];
    end else if (bypass) begin
      rd_data_o <= wr_data_i;
      rd_last_o <= wr_last_i;
    end
  end

endmodule

`default_nettype wire

/* design/pixel_stacker.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_stacker import cam_pkg::*; (
  input  wire    clk_camera,
  input  wire    recent_reset,
  input  wire    pix_valid_i,
  input  pixel_t pix_data_i,
  input  wire    pix_last_i,
  input  wire    abort_i,
  output logic   pix_ready_o,
  output logic   chunk_valid_o,
  output chunk_t chunk_data_o,
  output logic   chunk_last_o,
  input  wire    chunk_ready_i
);

  localparam int CNT_W = $clog2(PIX_PER_CHUNK);

  // slot of the pixel arriving next
  logic [CNT_W-1:0] count;

  // pixels enter at the top byte and move down
  chunk_t shift_q;
  chunk_t shift_next;
  chunk_t packed_chunk;

  logic accept;
  logic flush;

  // blocked only while a finished chunk is still waiting
  assign pix_ready_o = ~chunk_valid_o | chunk_ready_i;
  assign accept      = pix_valid_i & pix_ready_o;
  assign flush       = accept &
                       ((count == CNT_W'(PIX_PER_CHUNK - 1)) | pix_last_i);

  assign shift_next = {pix_data_i, shift_q[$bits(chunk_t)-1:8]};

  // short chunk slides down to byte 0, zeros fill the top
  assign packed_chunk = shift_next >> (8 * (CNT_W'(PIX_PER_CHUNK - 1) - count));

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      count         <= '0;
      chunk_valid_o <= 1'b0;
    end else begin
      if (chunk_valid_o && chunk_ready_i) begin
        chunk_valid_o <= 1'b0;
      end
      if (abort_i) begin
        // drop the partial chunk, a waiting chunk stays put
        count <= '0;
      end else if (flush) begin
        count         <= '0;
        chunk_valid_o <= 1'b1;
      end else if (accept) begin
        count <= count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (accept) begin
      shift_q <= shift_next;
    end
    if (flush && !abort_i) begin
      chunk_data_o <= packed_chunk;
      chunk_last_o <= pix_last_i;
    end
  end

endmodule

`default_nettype wire

/* design/capture_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module capture_ctrl import cam_pkg::*; #(
  parameter int H_RES = DEF_H_RES,
  parameter int V_RES = DEF_V_RES
) (
  input  wire          clk_camera,
  input  wire          recent_reset,
  input  wire          pix_valid_i,
  input  pixel_t       pix_data_i,
  input  hcount_t      pix_hcount_i,
  input  vcount_t      pix_vcount_i,
  input  wire          frame_start_i,
  input  wire          stk_ready_i,
  output logic         stk_valid_o,
  output pixel_t       stk_data_o,
  output logic         stk_last_o,
  output logic         stk_abort_o,
  output logic         capturing_o,
  output logic         overflow_o,
  output frame_count_t frame_count_o
);

  capture_state_t state;

  logic lost;
  logic is_last;

  // pixel offered to a stalled stacker has nowhere to go
  assign lost = stk_valid_o & ~stk_ready_i;

  // bottom right corner closes the frame
  assign is_last = (pix_hcount_i == hcount_t'(H_RES - 1)) &&
                   (pix_vcount_i == vcount_t'(V_RES - 1));

  assign capturing_o = (state == CAP_RUN);

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      state         <= CAP_IDLE;
      stk_valid_o   <= 1'b0;
      stk_abort_o   <= 1'b0;
      overflow_o    <= 1'b0;
      frame_count_o <= '0;
    end else begin
      stk_valid_o <= 1'b0;
      stk_abort_o <= 1'b0;

      // a frame counts once its last pixel is in the stacker
      if (stk_valid_o && stk_last_o && stk_ready_i) begin
        frame_count_o <= frame_count_o + 1'b1;
      end

      case (state)
        CAP_IDLE: begin
          state <= CAP_WAIT_FRAME;
        end
        CAP_WAIT_FRAME: begin
          // skip the partial frame seen at start-up
          if (frame_start_i) begin
            state <= CAP_RUN;
          end
        end
        CAP_RUN: begin
          if (lost) begin
            // sticky until reset
            overflow_o  <= 1'b1;
            stk_abort_o <= 1'b1;
            state       <= CAP_DROP;
          end else if (frame_start_i) begin
            // realign chunk boundary with the new frame
            stk_abort_o <= 1'b1;
          end else begin
            stk_valid_o <= pix_valid_i;
          end
        end
        CAP_DROP: begin
          // rest of this frame is discarded
          if (frame_start_i) begin
            state <= CAP_RUN;
          end
        end
        default: begin
          state <= CAP_IDLE;
        end
      endcase
    end
  end

  // payload follows every incoming pixel
  always_ff @(posedge clk_camera) begin
    if (pix_valid_i) begin
      stk_data_o <= pix_data_i;
      stk_last_o <= is_last;
    end
  end

endmodule

`default_nettype wire

/* design/luma_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module luma_capture import cam_pkg::*; #(
  parameter int H_RES = DEF_H_RES
) (
  input  wire     clk_camera,
  input  wire     recent_reset,
  input  pixel_t  cam_d_i,
  input  wire     cam_pclk_i,
  input  wire     cam_hsync_i,
  input  wire     cam_vsync_i,
  output logic    pix_valid_o,
  output pixel_t  pix_data_o,
  output hcount_t pix_hcount_o,
  output vcount_t pix_vcount_o,
  output logic    frame_start_o
);

  // two flop synchronizers, all camera pins
  pixel_t d_s1, d_s2;
  logic   pclk_s1, pclk_s2, pclk_q;
  logic   hs_s1, hs_s2, hs_q;
  logic   vs_s1, vs_s2, vs_q;

  // position within the frame
  hcount_t col;
  vcount_t row;

  logic pclk_rise;
  logic hs_fall;
  logic vs_rise;
  logic take_pix;

  // pins are asynchronous, so no reset on the sampling flops
  always_ff @(posedge clk_camera) begin
    d_s1    <= cam_d_i;
    d_s2    <= d_s1;
    pclk_s1 <= cam_pclk_i;
    pclk_s2 <= pclk_s1;
    hs_s1   <= cam_hsync_i;
    hs_s2   <= hs_s1;
    vs_s1   <= cam_vsync_i;
    vs_s2   <= vs_s1;
    // previous values for edge detect
    pclk_q  <= pclk_s2;
    hs_q    <= hs_s2;
    vs_q    <= vs_s2;
  end

  assign pclk_rise = pclk_s2 & ~pclk_q;
  assign hs_fall   = hs_q & ~hs_s2;
  assign vs_rise   = vs_s2 & ~vs_q;
  // sample only inside the active part of a row
  assign take_pix  = pclk_rise & hs_s2;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      col           <= '0;
      row           <= '0;
      pix_valid_o   <= 1'b0;
      frame_start_o <= 1'b0;
    end else begin
      pix_valid_o   <= take_pix;
      frame_start_o <= vs_rise;
      if (vs_s2) begin
        // vsync level holds the counters at the origin
        col <= '0;
        row <= '0;
      end else if (hs_fall) begin
        col <= '0;
        row <= row + 1'b1;
      end else if (take_pix && col != hcount_t'(H_RES)) begin
        // saturate so overlong rows never wrap into valid columns
        col <= col + 1'b1;
      end
    end
  end

  // pixel payload, tagged with its position
  always_ff @(posedge clk_camera) begin
    if (take_pix) begin
      pix_data_o   <= d_s2;
      pix_hcount_o <= col;
      pix_vcount_o <= row;
    end
  end

endmodule

`default_nettype wire

/* design/cam_pkg.sv */
`default_nettype none

package cam_pkg;

  // one luminance sample from the camera
  typedef logic [7:0] pixel_t;

  // sixteen samples, first sample in bits 7:0
  typedef logic [127:0] chunk_t;

  // column and row positions
  typedef logic [10:0] hcount_t;
  typedef logic [9:0] vcount_t;

  // completed frames since reset
  typedef logic [15:0] frame_count_t;

  // pixels per DRAM word
  localparam int PIX_PER_CHUNK = 16;

  // 640x360 luminance frame by default
  localparam int DEF_H_RES = 640;
  localparam int DEF_V_RES = 360;

  // chunks held ahead of the output stream
  localparam int DEF_FIFO_DEPTH = 8;

  // capture control FSM
  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_WAIT_FRAME,
    CAP_RUN,
    CAP_DROP
  } capture_state_t;

endpackage

`default_nettype wire
